// ==== logic/nlb_pkg.sv ====
package nlb_pkg;

   // --------------------------------------------------
   // Widths
   // --------------------------------------------------

   // Line address width, addresses wrap at this size
   localparam int ADDR_LMT = 20;
   // One cache line is a single 64-bit word here
   localparam int LINE_W   = 64;
   // CSR bus byte address and data widths
   localparam int CSR_AW   = 12;
   localparam int CSR_DW   = 32;

   // --------------------------------------------------
   // CSR byte offsets
   // --------------------------------------------------
   localparam logic [CSR_AW-1:0] CSR_SCRATCHPAD0 = 12'h100;
   localparam logic [CSR_AW-1:0] CSR_SRC_ADDR    = 12'h120;
   localparam logic [CSR_AW-1:0] CSR_DST_ADDR    = 12'h128;
   localparam logic [CSR_AW-1:0] CSR_NUM_LINES   = 12'h130;
   localparam logic [CSR_AW-1:0] CSR_CTL         = 12'h138;
   localparam logic [CSR_AW-1:0] CSR_CFG         = 12'h140;
   // Status bit 0 is done, bit 1 is running
   localparam logic [CSR_AW-1:0] CSR_STATUS      = 12'h160;
   localparam logic [CSR_AW-1:0] CSR_NUM_READS   = 12'h168;
   localparam logic [CSR_AW-1:0] CSR_NUM_WRITES  = 12'h170;

   // Test mode codes, cfg bits [4:2]
   localparam logic [2:0] M_LPBK1 = 3'b000;
   localparam logic [2:0] M_READ  = 3'b001;
   localparam logic [2:0] M_WRITE = 3'b010;
   localparam logic [2:0] M_TRPUT = 3'b011;

   // Upper half of generated write data, lower half is the line index
   localparam logic [31:0] WR_TAG = 32'hA5C3_0000;

   typedef logic [LINE_W-1:0]   line_t;
   typedef logic [ADDR_LMT-1:0] line_addr_t;

   // Field view of the configuration word
   typedef struct packed {
      logic [3:0]  rsvd_hi;
      logic [7:0]  test_cfg;
      logic [10:0] rsvd_mid;
      logic        delay_en;
      logic        rsvd_lo;
      logic [1:0]  multi_cl_len;
      logic [2:0]  mode;
      logic        cont;
      logic        wrthru;
   } cfg_fields_t;

   // Stored and read back raw, decoded as fields for the mode
   typedef union packed {
      logic [CSR_DW-1:0] raw;
      cfg_fields_t       f;
   } cfg_word_u;

endpackage

// ==== logic/test_ctl_if.sv ====
`timescale 1ns/1ps

interface test_ctl_if;
   import nlb_pkg::*;

   // Configuration side, driven by the CSR block
   logic              go;
   logic              test_rst_n;
   logic [2:0]        mode;
   line_addr_t        src_addr;
   line_addr_t        dst_addr;
   logic [CSR_DW-1:0] num_lines;

   // Status side, driven by the engine
   logic              running;
   logic              done;
   logic [CSR_DW-1:0] num_reads;
   logic [CSR_DW-1:0] num_writes;

   modport csr (
      output go, test_rst_n, mode, src_addr, dst_addr, num_lines,
      input  running, done, num_reads, num_writes
   );

   modport engine (
      input  go, test_rst_n, mode, src_addr, dst_addr, num_lines,
      output running, done, num_reads, num_writes
   );

endinterface

// ==== logic/mem_req_if.sv ====
`timescale 1ns/1ps

interface mem_req_if;
   import nlb_pkg::*;

   // Requests, held stable until the matching sent pulse
   logic       rd_req;
   line_addr_t rd_addr;
   logic       wr_req;
   line_addr_t wr_addr;
   line_t      wr_data;

   // One-cycle strobes in the Wishbone ack cycle
   logic       rd_sent;
   logic       wr_sent;
   logic       rsp_valid;
   line_t      rd_data;

   modport engine (
      output rd_req, rd_addr, wr_req, wr_addr, wr_data,
      input  rd_sent, wr_sent, rsp_valid, rd_data
   );

   modport requestor (
      input  rd_req, rd_addr, wr_req, wr_addr, wr_data,
      output rd_sent, wr_sent, rsp_valid, rd_data
   );

endinterface

// ==== logic/nlb_csr.sv ====
`timescale 1ns/1ps

module nlb_csr (
   input  logic                       Clk_400,
   input  logic                       rst,
   input  logic [nlb_pkg::CSR_AW-1:0] wb_adr,
   input  logic [nlb_pkg::CSR_DW-1:0] wb_dat_w,
   output logic [nlb_pkg::CSR_DW-1:0] wb_dat_r,
   input  logic                       wb_we,
   input  logic                       wb_stb,
   input  logic                       wb_cyc,
   output logic                       wb_ack,
   test_ctl_if.csr                    ctl
);
   import nlb_pkg::*;

   logic              access;
   logic              wr_en;
   logic              cfg_lock;
   logic [CSR_DW-1:0] rd_mux;

   // Register file
   logic [CSR_DW-1:0] scratch_q;
   logic [CSR_DW-1:0] src_q;
   logic [CSR_DW-1:0] dst_q;
   logic [CSR_DW-1:0] num_lines_q;
   logic [1:0]        ctl_q;
   cfg_word_u         cfg_q;
   logic              go_q;

   // --------------------------------------------------
   // Bus decode
   // --------------------------------------------------

   // New access in the cycle before ack rises
   assign access = wb_cyc & wb_stb & ~wb_ack;
   assign wr_en  = access & wb_we;

   // Configuration is frozen while a test runs
   assign cfg_lock = ctl.running;

   // Ack one cycle after strobe and low again for one cycle after
   always_ff @(posedge Clk_400)
   begin
      if (rst)
      begin
         wb_ack <= 1'b0;
      end
      else
      begin
         wb_ack <= access;
      end
   end

   // --------------------------------------------------
   // Register writes
   // --------------------------------------------------
   always_ff @(posedge Clk_400)
   begin
      if (rst)
      begin
         scratch_q   <= '0;
         src_q       <= '0;
         dst_q       <= '0;
         num_lines_q <= '0;
         ctl_q       <= '0;
         cfg_q       <= '0;
         go_q        <= 1'b0;
      end
      else
      begin
         // Start is a single pulse
         go_q <= 1'b0;
         if (wr_en)
         begin
            case (wb_adr)
               CSR_SCRATCHPAD0: scratch_q <= wb_dat_w;
               CSR_SRC_ADDR:    if (!cfg_lock) src_q <= wb_dat_w;
               CSR_DST_ADDR:    if (!cfg_lock) dst_q <= wb_dat_w;
               CSR_NUM_LINES:   if (!cfg_lock) num_lines_q <= wb_dat_w;
               CSR_CFG:         if (!cfg_lock) cfg_q.raw <= wb_dat_w;
               CSR_CTL:
               begin
                  ctl_q <= wb_dat_w[1:0];
                  // Start needs test reset released in the same write
                  go_q  <= wb_dat_w[1] & wb_dat_w[0] & ~ctl.running;
               end
               default: ;
            endcase
         end
      end
   end

   // --------------------------------------------------
   // Readback
   // --------------------------------------------------
   always_comb
   begin
      rd_mux = '0;
      case (wb_adr)
         CSR_SCRATCHPAD0: rd_mux = scratch_q;
         CSR_SRC_ADDR:    rd_mux = src_q;
         CSR_DST_ADDR:    rd_mux = dst_q;
         CSR_NUM_LINES:   rd_mux = num_lines_q;
         CSR_CTL:         rd_mux = {{(CSR_DW-2){1'b0}}, ctl_q};
         CSR_CFG:         rd_mux = cfg_q.raw;
         CSR_STATUS:      rd_mux = {{(CSR_DW-2){1'b0}}, ctl.running, ctl.done};
         CSR_NUM_READS:   rd_mux = ctl.num_reads;
         CSR_NUM_WRITES:  rd_mux = ctl.num_writes;
         default:         rd_mux = '0;
      endcase
   end

   // Read data lands together with ack
   always_ff @(posedge Clk_400)
   begin
      if (rst)
      begin
         wb_dat_r <= '0;
      end
      else if (access)
      begin
         wb_dat_r <= rd_mux;
      end
   end

   // Test controls toward the engine
   assign ctl.go         = go_q;
   assign ctl.test_rst_n = ctl_q[0];
   assign ctl.mode       = cfg_q.f.mode;
   assign ctl.src_addr   = src_q[ADDR_LMT-1:0];
   assign ctl.dst_addr   = dst_q[ADDR_LMT-1:0];
   assign ctl.num_lines  = num_lines_q;

endmodule

// ==== logic/nlb_engine.sv ====
`timescale 1ns/1ps

module nlb_engine (
   input  logic        Clk_400,
   input  logic        rst,
   test_ctl_if.engine  ctl,
   mem_req_if.engine   req
);
   import nlb_pkg::*;

   logic              running_q;
   logic              done_q;
   // Line indices, equal to the number of sent transfers
   logic [CSR_DW-1:0] rd_idx;
   logic [CSR_DW-1:0] wr_idx;
   logic [CSR_DW-1:0] rd_nxt;
   logic [CSR_DW-1:0] wr_nxt;

   // Loopback holding register
   line_t             hold_q;
   logic              hold_v;

   logic              lpbk;
   logic              rd_need;
   logic              wr_need;
   logic              fin;

   // --------------------------------------------------
   // Mode decode
   // --------------------------------------------------
   assign lpbk    = (ctl.mode == M_LPBK1);
   assign rd_need = lpbk | (ctl.mode == M_READ) | (ctl.mode == M_TRPUT);
   assign wr_need = lpbk | (ctl.mode == M_WRITE) | (ctl.mode == M_TRPUT);

   // Counts after this cycle's strobes
   assign rd_nxt = rd_idx + {{(CSR_DW-1){1'b0}}, req.rd_sent};
   assign wr_nxt = wr_idx + {{(CSR_DW-1){1'b0}}, req.wr_sent};

   // Streams not used by the mode count as finished
   assign fin = (!rd_need || rd_nxt == ctl.num_lines) &&
                (!wr_need || wr_nxt == ctl.num_lines);

   // --------------------------------------------------
   // Request generation
   // --------------------------------------------------

   // Loopback waits for the held line to be written before the next read
   assign req.rd_req = running_q & rd_need & (rd_idx < ctl.num_lines) & ~(lpbk & hold_v);
   assign req.wr_req = running_q & wr_need & (wr_idx < ctl.num_lines) & (~lpbk | hold_v);

   // Base plus index, wraps at the line address width
   assign req.rd_addr = ctl.src_addr + rd_idx[ADDR_LMT-1:0];
   assign req.wr_addr = ctl.dst_addr + wr_idx[ADDR_LMT-1:0];

   // Copy data in loopback, tagged pattern otherwise
   assign req.wr_data = lpbk ? hold_q : {WR_TAG, wr_idx};

   // --------------------------------------------------
   // Sequencer
   // --------------------------------------------------
   always_ff @(posedge Clk_400)
   begin
      if (rst || !ctl.test_rst_n)
      begin
         running_q <= 1'b0;
         done_q    <= 1'b0;
         rd_idx    <= '0;
         wr_idx    <= '0;
         hold_v    <= 1'b0;
      end
      else if (ctl.go && !running_q)
      begin
         rd_idx <= '0;
         wr_idx <= '0;
         hold_v <= 1'b0;
         // Empty test or unknown mode finishes right away
         if (ctl.num_lines == '0 || ctl.mode[2])
         begin
            running_q <= 1'b0;
            done_q    <= 1'b1;
         end
         else
         begin
            running_q <= 1'b1;
            done_q    <= 1'b0;
         end
      end
      else if (running_q)
      begin
         rd_idx <= rd_nxt;
         wr_idx <= wr_nxt;
         if (lpbk && req.rsp_valid)
         begin
            hold_v <= 1'b1;
         end
         else if (req.wr_sent)
         begin
            hold_v <= 1'b0;
         end
         if (fin)
         begin
            running_q <= 1'b0;
            done_q    <= 1'b1;
         end
      end
   end

   // Read data capture
   always_ff @(posedge Clk_400)
   begin
      if (req.rsp_valid)
      begin
         hold_q <= req.rd_data;
      end
   end

   assign ctl.running    = running_q;
   assign ctl.done       = done_q;
   assign ctl.num_reads  = rd_idx;
   assign ctl.num_writes = wr_idx;

endmodule

// ==== logic/nlb_requestor.sv ====
`timescale 1ns/1ps

module nlb_requestor (
   input  logic                 Clk_400,
   input  logic                 rst,
   mem_req_if.requestor         req,
   output nlb_pkg::line_addr_t  mem_adr,
   output nlb_pkg::line_t       mem_dat_w,
   input  nlb_pkg::line_t       mem_dat_r,
   output logic                 mem_we,
   output logic                 mem_cyc,
   output logic                 mem_stb,
   input  logic                 mem_ack
);
   import nlb_pkg::*;

   // Idle when low, one Wishbone cycle open when high
   logic       busy;
   logic       we_q;
   line_addr_t adr_q;
   line_t      dat_q;
   logic       done_xfer;

   assign done_xfer = busy & mem_ack;

   // --------------------------------------------------
   // Control, writes win over reads
   // --------------------------------------------------
   always_ff @(posedge Clk_400)
   begin
      if (rst)
      begin
         busy <= 1'b0;
         we_q <= 1'b0;
      end
      else if (!busy)
      begin
         if (req.wr_req)
         begin
            busy <= 1'b1;
            we_q <= 1'b1;
         end
         else if (req.rd_req)
         begin
            busy <= 1'b1;
            we_q <= 1'b0;
         end
      end
      else if (mem_ack)
      begin
         busy <= 1'b0;
      end
   end

   // Address and data latch when a cycle opens
   always_ff @(posedge Clk_400)
   begin
      if (!busy)
      begin
         adr_q <= req.wr_req ? req.wr_addr : req.rd_addr;
         dat_q <= req.wr_data;
      end
   end

   // Bus held stable until ack
   assign mem_cyc   = busy;
   assign mem_stb   = busy;
   assign mem_we    = we_q;
   assign mem_adr   = adr_q;
   assign mem_dat_w = dat_q;

   // Strobes back to the engine in the ack cycle
   assign req.wr_sent   = done_xfer & we_q;
   assign req.rd_sent   = done_xfer & ~we_q;
   assign req.rsp_valid = done_xfer & ~we_q;
   assign req.rd_data   = mem_dat_r;

endmodule

// ==== logic/nlb_top.sv ====
`timescale 1ns/1ps

module nlb_top (
   input  logic                       Clk_400,
   input  logic                       rst,
   // CSR slave port
   input  logic [nlb_pkg::CSR_AW-1:0] csr_adr,
   input  logic [nlb_pkg::CSR_DW-1:0] csr_dat_w,
   output logic [nlb_pkg::CSR_DW-1:0] csr_dat_r,
   input  logic                       csr_we,
   input  logic                       csr_stb,
   input  logic                       csr_cyc,
   output logic                       csr_ack,
   // Memory master port
   output nlb_pkg::line_addr_t        mem_adr,
   output nlb_pkg::line_t             mem_dat_w,
   input  nlb_pkg::line_t             mem_dat_r,
   output logic                       mem_we,
   output logic                       mem_cyc,
   output logic                       mem_stb,
   input  logic                       mem_ack
);

   // Configuration and status between CSR block and engine
   test_ctl_if ctl_bus ();
   // Line requests between engine and bus master
   mem_req_if  req_bus ();

   nlb_csr u_csr (
      .Clk_400  (Clk_400),
      .rst      (rst),
      .wb_adr   (csr_adr),
      .wb_dat_w (csr_dat_w),
      .wb_dat_r (csr_dat_r),
      .wb_we    (csr_we),
      .wb_stb   (csr_stb),
      .wb_cyc   (csr_cyc),
      .wb_ack   (csr_ack),
      .ctl      (ctl_bus.csr)
   );

   nlb_engine u_engine (
      .Clk_400 (Clk_400),
      .rst     (rst),
      .ctl     (ctl_bus.engine),
      .req     (req_bus.engine)
   );

   nlb_requestor u_requestor (
      .Clk_400   (Clk_400),
      .rst       (rst),
      .req       (req_bus.requestor),
      .mem_adr   (mem_adr),
      .mem_dat_w (mem_dat_w),
      .mem_dat_r (mem_dat_r),
      .mem_we    (mem_we),
      .mem_cyc   (mem_cyc),
      .mem_stb   (mem_stb),
      .mem_ack   (mem_ack)
   );

endmodule

// ==== bench/tb_nlb.sv ====
`timescale 1ns/1ps

module tb_nlb;
   import nlb_pkg::*;

   // Lines in the test that checks the configuration lock
   localparam int unsigned LONG_LINES = 200;

   logic              Clk_400 = 1'b0;
   logic              rst = 1'b1;
   logic [CSR_AW-1:0] csr_adr = '0;
   logic [CSR_DW-1:0] csr_dat_w = '0;
   logic [CSR_DW-1:0] csr_dat_r;
   logic              csr_we = 1'b0;
   logic              csr_stb = 1'b0;
   logic              csr_cyc = 1'b0;
   logic              csr_ack;
   line_addr_t        mem_adr;
   line_t             mem_dat_w;
   line_t             mem_dat_r = '0;
   logic              mem_we;
   logic              mem_cyc;
   logic              mem_stb;
   logic              mem_ack = 1'b0;

   // Bus memory, and the expected contents after a test
   line_t             mem [line_addr_t];
   line_t             exp_mem [line_addr_t];
   int unsigned       wait_left = 0;
   logic              pending = 1'b0;
   int unsigned       limit_cycles = 0;
   int unsigned       lines_tab [8];

   nlb_top DUT (
      .Clk_400   (Clk_400),
      .rst       (rst),
      .csr_adr   (csr_adr),
      .csr_dat_w (csr_dat_w),
      .csr_dat_r (csr_dat_r),
      .csr_we    (csr_we),
      .csr_stb   (csr_stb),
      .csr_cyc   (csr_cyc),
      .csr_ack   (csr_ack),
      .mem_adr   (mem_adr),
      .mem_dat_w (mem_dat_w),
      .mem_dat_r (mem_dat_r),
      .mem_we    (mem_we),
      .mem_cyc   (mem_cyc),
      .mem_stb   (mem_stb),
      .mem_ack   (mem_ack)
   );

   // 8 ns period
   always #4 Clk_400 = ~Clk_400;

   // Lines never written read back a pattern of the whole address
   function automatic line_t fill_line(input line_addr_t a);
      return {12'hC3A, a, 12'h5E1, ~a};
   endfunction

   // --------------------------------------------------
   // Wishbone memory slave, 0 to 3 wait states
   // --------------------------------------------------
   always @(posedge Clk_400)
   begin
      if (rst)
      begin
         mem_ack <= 1'b0;
         pending = 1'b0;
      end
      else
      begin
         mem_ack <= 1'b0;
         if (mem_cyc && mem_stb && !mem_ack)
         begin
            // Wait count drawn once when the cycle opens
            if (!pending)
            begin
               pending = 1'b1;
               wait_left = $urandom_range(3, 0);
            end
            if (wait_left == 0)
            begin
               pending = 1'b0;
               mem_ack <= 1'b1;
               if (mem_we)
               begin
                  mem[mem_adr] = mem_dat_w;
               end
               else
               begin
                  mem_dat_r <= mem.exists(mem_adr) ? mem[mem_adr] : fill_line(mem_adr);
               end
            end
            else
            begin
               wait_left = wait_left - 1;
            end
         end
      end
   end

   // --------------------------------------------------
   // Checks and CSR access
   // --------------------------------------------------
   task automatic fail_run(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp)
      else
      begin
         fail_run($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
      end
   endtask

   task automatic check_line(input string name, input line_t exp, input line_t act);
      assert (act === exp)
      else
      begin
         fail_run($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
      end
   endtask

   // Host holds the strobe until ack, then drops it for a cycle
   task automatic csr_write(input logic [CSR_AW-1:0] adr, input logic [CSR_DW-1:0] data);
      @(posedge Clk_400);
      csr_adr   <= adr;
      csr_dat_w <= data;
      csr_we    <= 1'b1;
      csr_cyc   <= 1'b1;
      csr_stb   <= 1'b1;
      do
      begin
         @(posedge Clk_400);
      end
      while (csr_ack !== 1'b1);
      csr_we  <= 1'b0;
      csr_cyc <= 1'b0;
      csr_stb <= 1'b0;
   endtask

   task automatic csr_read(input logic [CSR_AW-1:0] adr, output logic [CSR_DW-1:0] data);
      @(posedge Clk_400);
      csr_adr <= adr;
      csr_we  <= 1'b0;
      csr_cyc <= 1'b1;
      csr_stb <= 1'b1;
      do
      begin
         @(posedge Clk_400);
      end
      while (csr_ack !== 1'b1);
      // Read data is valid with ack
      data = csr_dat_r;
      csr_cyc <= 1'b0;
      csr_stb <= 1'b0;
   endtask

   task automatic rw_check(input string name, input logic [CSR_AW-1:0] adr);
      logic [CSR_DW-1:0] v;
      logic [CSR_DW-1:0] rd;
      v = $urandom;
      csr_write(adr, v);
      csr_read(adr, rd);
      check_word(name, v, rd);
   endtask

   // --------------------------------------------------
   // One test run with its reference model
   // --------------------------------------------------
   task automatic run_test(input string name, input logic [2:0] mode, input int unsigned n,
                           input bit long_chk);
      line_addr_t        src;
      line_addr_t        dst;
      line_addr_t        a;
      line_addr_t        s;
      logic [CSR_DW-1:0] st;
      logic [CSR_DW-1:0] rd;
      int unsigned       exp_rd;
      int unsigned       exp_wr;
      src = line_addr_t'($urandom);
      dst = line_addr_t'($urandom);
      // Random source lines, written behind the bus
      for (int unsigned i = 0; i < n; i++)
      begin
         mem[src + line_addr_t'(i)] = {$urandom, $urandom};
      end
      // Copy runs line by line in order, so overlap is modelled the same way
      exp_mem = mem;
      for (int unsigned i = 0; i < n; i++)
      begin
         a = dst + line_addr_t'(i);
         s = src + line_addr_t'(i);
         if (mode == M_LPBK1)
         begin
            exp_mem[a] = exp_mem.exists(s) ? exp_mem[s] : fill_line(s);
         end
         else if (mode != M_READ)
         begin
            exp_mem[a] = {WR_TAG, i};
         end
      end
      exp_rd = (mode == M_WRITE) ? 0 : n;
      exp_wr = (mode == M_READ) ? 0 : n;

      // Test reset low, program, then release with start
      csr_write(CSR_CTL, 32'h0);
      csr_write(CSR_SRC_ADDR, {12'h0, src});
      csr_write(CSR_DST_ADDR, {12'h0, dst});
      csr_write(CSR_NUM_LINES, n);
      // Fields other than mode get random filler
      csr_write(CSR_CFG, ($urandom & ~32'h1C) | {27'd0, mode, 2'b00});
      csr_write(CSR_CTL, 32'h3);

      if (long_chk)
      begin
         csr_read(CSR_STATUS, st);
         check_word({name, " status running"}, 32'h2, st);
         csr_write(CSR_NUM_LINES, $urandom);
         csr_read(CSR_NUM_LINES, rd);
         check_word({name, " num_lines locked"}, n, rd);
      end

      // Poll for done, the watchdog bounds this
      do
      begin
         csr_read(CSR_STATUS, st);
      end
      while (st[0] !== 1'b1);
      check_word({name, " status"}, 32'h1, st);
      csr_read(CSR_NUM_READS, rd);
      check_word({name, " num_reads"}, exp_rd, rd);
      csr_read(CSR_NUM_WRITES, rd);
      check_word({name, " num_writes"}, exp_wr, rd);

      // Whole memory against the model
      check_word({name, " line count"}, exp_mem.num(), mem.num());
      if (exp_mem.first(a))
      begin
         do
         begin
            check_line($sformatf("%s line %h", name, a), exp_mem[a],
                       mem.exists(a) ? mem[a] : fill_line(a));
         end
         while (exp_mem.next(a));
      end

      if (long_chk)
      begin
         // Test reset clears status and counters
         csr_write(CSR_CTL, 32'h0);
         csr_read(CSR_STATUS, rd);
         check_word({name, " status cleared"}, 32'h0, rd);
         csr_read(CSR_NUM_READS, rd);
         check_word({name, " num_reads cleared"}, 32'h0, rd);
         csr_read(CSR_NUM_WRITES, rd);
         check_word({name, " num_writes cleared"}, 32'h0, rd);
      end
   endtask

   // --------------------------------------------------
   // Main sequence
   // --------------------------------------------------
   initial
   begin
      logic [CSR_DW-1:0] rd;
      int unsigned       total;
      void'($urandom(5248));
      total = LONG_LINES;
      for (int k = 0; k < 8; k++)
      begin
         lines_tab[k] = $urandom_range(32, 1);
         total += lines_tab[k];
      end
      // About 16 cycles per line, margin for CSR traffic
      limit_cycles = total * 16 + 3000;
      repeat (5) @(posedge Clk_400);
      rst <= 1'b0;

      rw_check("scratchpad", CSR_SCRATCHPAD0);
      rw_check("src_addr", CSR_SRC_ADDR);
      rw_check("dst_addr", CSR_DST_ADDR);
      rw_check("num_lines", CSR_NUM_LINES);
      rw_check("cfg", CSR_CFG);
      csr_write(12'h104, $urandom);
      csr_read(12'h104, rd);
      check_word("unmapped", 32'h0, rd);

      for (int r = 0; r < 2; r++)
      begin
         run_test("lpbk1", M_LPBK1, lines_tab[4*r], 1'b0);
         run_test("read", M_READ, lines_tab[4*r+1], 1'b0);
         run_test("write", M_WRITE, lines_tab[4*r+2], 1'b0);
         run_test("trput", M_TRPUT, lines_tab[4*r+3], 1'b0);
      end
      run_test("long lpbk1", M_LPBK1, LONG_LINES, 1'b1);

      $display("TEST OK");
      $finish;
   end

   // Watchdog, armed once the line counts are known
   initial
   begin
      wait (limit_cycles != 0);
      repeat (limit_cycles) @(posedge Clk_400);
      fail_run("Watchdog expired before the tests completed");
   end

endmodule

// ==== src.f ====
logic/nlb_pkg.sv
logic/test_ctl_if.sv
logic/mem_req_if.sv
logic/nlb_csr.sv
logic/nlb_engine.sv
logic/nlb_requestor.sv
logic/nlb_top.sv
bench/tb_nlb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_nlb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
